// File: hdl/cp0_cfg.svh
`ifndef CP0_CFG_SVH
`define CP0_CFG_SVH

// Register codes are {number, select}
`define CP0_INDEX     {5'd0, 3'd0}
`define CP0_ENTRYLO0  {5'd2, 3'd0}
`define CP0_ENTRYLO1  {5'd3, 3'd0}
`define CP0_CONTEXT   {5'd4, 3'd0}
`define CP0_BADVADDR  {5'd8, 3'd0}
`define CP0_COUNT     {5'd9, 3'd0}
`define CP0_ENTRYHI   {5'd10, 3'd0}
`define CP0_COMPARE   {5'd11, 3'd0}
`define CP0_STATUS    {5'd12, 3'd0}
`define CP0_CAUSE     {5'd13, 3'd0}
`define CP0_EPC       {5'd14, 3'd0}
`define CP0_PRID      {5'd15, 3'd0}
`define CP0_EBASE     {5'd15, 3'd1}
`define CP0_CONFIG    {5'd16, 3'd0}
`define CP0_CONFIG1   {5'd16, 3'd1}

`define CP0_STATUS_RST 32'h10400004 // CU0, BEV and ERL set
`define CP0_EBASE_RST  32'h80000000

`define CP0_PRID_VAL    {8'd0, 8'd1, 16'h8000} // 4Kc class core
`define CP0_CONFIG1_VAL {1'b0, 6'd15, 3'd0, 3'd5, 3'd0, 3'd0, 3'd5, 3'd0, 7'd0}
`define CP0_KSEG0_UNCACHED_K0 3'd2

`endif

// File: hdl/cp0_pkg.sv
package cp0_pkg;

    // Register or data word
    typedef logic [31:0] cp0_word_t;

    // Register number in 7:3, select in 2:0
    typedef logic [7:0] cp0_regsel_t;

    // Cause.ExcCode
    typedef logic [4:0] cp0_excode_t;

    // Address space ID as held in EntryHi
    typedef logic [7:0] cp0_asid_t;

    // Virtual page number of an even/odd page pair
    typedef logic [18:0] cp0_vpn2_t;

    // Packed TLB entry fields handed to the TLB
    typedef logic [89:0] cp0_tlbcfg_t;

endpackage

// File: hdl/cp0_wr_if.sv
interface cp0_wr_if;

    cp0_pkg::cp0_word_t   wr_data;

    logic                 wr_index;
    logic                 wr_entrylo0;
    logic                 wr_entrylo1;
    logic                 wr_context;
    logic                 wr_count;
    logic                 wr_entryhi;
    logic                 wr_compare;
    logic                 wr_status;
    logic                 wr_cause;
    logic                 wr_epc;
    logic                 wr_ebase;
    logic                 wr_config;

    logic                 exp_take;
    logic                 exl_clear;
    logic                 probe_load;

    cp0_pkg::cp0_word_t   exp_epc;
    logic                 exp_bd;
    cp0_pkg::cp0_excode_t exp_code;
    cp0_pkg::cp0_word_t   exp_bad_vaddr;
    logic                 exp_badv_we;
    cp0_pkg::cp0_asid_t   exp_asid;
    logic                 exp_asid_we;
    cp0_pkg::cp0_word_t   probe_result;

    modport ctrl (
        output wr_data, wr_index, wr_entrylo0, wr_entrylo1, wr_context, wr_count,
               wr_entryhi, wr_compare, wr_status, wr_cause, wr_epc, wr_ebase, wr_config,
               exp_take, exl_clear, probe_load, exp_epc, exp_bd, exp_code,
               exp_bad_vaddr, exp_badv_we, exp_asid, exp_asid_we, probe_result
    );

    modport regs (
        input  wr_data, wr_index, wr_entrylo0, wr_entrylo1, wr_context, wr_count,
               wr_entryhi, wr_compare, wr_status, wr_cause, wr_epc, wr_ebase, wr_config,
               exp_take, exl_clear, probe_load, exp_epc, exp_bd, exp_code,
               exp_bad_vaddr, exp_badv_we, exp_asid, exp_asid_we, probe_result
    );

endinterface

// File: hdl/cp0_ctrl.sv
`include "cp0_cfg.svh"

module cp0_ctrl (
    input  logic                 we_i,
    input  cp0_pkg::cp0_regsel_t wr_addr_i,
    input  cp0_pkg::cp0_word_t   data_i,
    input  logic                 en_exp_i,
    input  cp0_pkg::cp0_word_t   exp_epc_i,
    input  logic                 exp_bd_i,
    input  cp0_pkg::cp0_excode_t exp_code_i,
    input  cp0_pkg::cp0_word_t   exp_bad_vaddr_i,
    input  logic                 exp_badv_we_i,
    input  cp0_pkg::cp0_asid_t   exp_asid_i,
    input  logic                 exp_asid_we_i,
    input  logic                 clean_exl_i,
    input  logic                 we_probe_i,
    input  cp0_pkg::cp0_word_t   probe_result_i,
    cp0_wr_if.ctrl               wr
);

    assign wr.wr_data = data_i;

    // One strobe per register, with the event overrides folded in
    assign wr.wr_index    = we_i && (wr_addr_i == `CP0_INDEX) && !we_probe_i;
    assign wr.wr_entrylo0 = we_i && (wr_addr_i == `CP0_ENTRYLO0);
    assign wr.wr_entrylo1 = we_i && (wr_addr_i == `CP0_ENTRYLO1);
    assign wr.wr_context  = we_i && (wr_addr_i == `CP0_CONTEXT);
    assign wr.wr_count    = we_i && (wr_addr_i == `CP0_COUNT);
    assign wr.wr_entryhi  = we_i && (wr_addr_i == `CP0_ENTRYHI) && !en_exp_i;
    assign wr.wr_compare  = we_i && (wr_addr_i == `CP0_COMPARE);
    assign wr.wr_status   = we_i && (wr_addr_i == `CP0_STATUS);
    assign wr.wr_cause    = we_i && (wr_addr_i == `CP0_CAUSE);
    assign wr.wr_epc      = we_i && (wr_addr_i == `CP0_EPC) && !en_exp_i;
    assign wr.wr_ebase    = we_i && (wr_addr_i == `CP0_EBASE);
    assign wr.wr_config   = we_i && (wr_addr_i == `CP0_CONFIG);

    assign wr.exp_take   = en_exp_i;
    assign wr.exl_clear  = clean_exl_i; // Applied after exp_take in the register block
    assign wr.probe_load = we_probe_i;

    assign wr.exp_epc       = exp_epc_i;
    assign wr.exp_bd        = exp_bd_i;
    assign wr.exp_code      = exp_code_i;
    assign wr.exp_bad_vaddr = exp_bad_vaddr_i;
    assign wr.exp_badv_we   = exp_badv_we_i;
    assign wr.exp_asid      = exp_asid_i;
    assign wr.exp_asid_we   = exp_asid_we_i;
    assign wr.probe_result  = probe_result_i;

endmodule

// File: hdl/cp0_timer.sv
module cp0_timer (
    input  logic               clk,
    input  logic               rst_n,
    cp0_wr_if.regs             wr,
    output cp0_pkg::cp0_word_t count_o,
    output cp0_pkg::cp0_word_t compare_o,
    output logic               timer_int_o
);

    cp0_pkg::cp0_word_t count_q;
    cp0_pkg::cp0_word_t compare_q;
    logic               hit;

    // A Compare of zero disables the timer
    assign hit = (compare_q != '0) && (compare_q == count_q);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count_q     <= '0;
            compare_q   <= '0;
            timer_int_o <= 1'b0;
        end else begin
            if (wr.wr_count) begin
                count_q <= wr.wr_data;
            end else begin
                count_q <= count_q + 32'd1;
            end
            if (wr.wr_compare) begin
                compare_q   <= wr.wr_data;
                timer_int_o <= 1'b0; // Acknowledge
            end else if (hit) begin
                timer_int_o <= 1'b1;
            end
        end
    end

    assign count_o   = count_q;
    assign compare_o = compare_q;

endmodule

// File: hdl/cp0_except_regs.sv
`include "cp0_cfg.svh"

module cp0_except_regs (
    input  logic               clk,
    input  logic               rst_n,
    cp0_wr_if.regs             wr,
    output cp0_pkg::cp0_word_t status_o,
    output cp0_pkg::cp0_word_t cause_o,
    output cp0_pkg::cp0_word_t epc_o,
    output cp0_pkg::cp0_word_t ebase_o,
    output cp0_pkg::cp0_word_t badvaddr_o,
    output logic               user_mode_o,
    output logic               allow_int_o,
    output logic               in_exl_o,
    output logic               boot_exp_vec_o,
    output logic               special_int_vec_o,
    output logic [7:0]         interrupt_mask_o,
    output logic [1:0]         software_int_o
);

    cp0_pkg::cp0_word_t status_q;
    cp0_pkg::cp0_word_t cause_q;
    cp0_pkg::cp0_word_t ebase_q;
    cp0_pkg::cp0_word_t epc_q;
    cp0_pkg::cp0_word_t badvaddr_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            status_q <= `CP0_STATUS_RST;
            cause_q  <= '0;
            ebase_q  <= `CP0_EBASE_RST;
        end else begin
            if (wr.wr_status) begin
                status_q[28]   <= wr.wr_data[28];   // CU0
                status_q[22]   <= wr.wr_data[22];   // BEV
                status_q[15:8] <= wr.wr_data[15:8]; // IM
                status_q[4]    <= wr.wr_data[4];    // UM
                status_q[2:0]  <= wr.wr_data[2:0];  // ERL, EXL, IE
            end
            if (wr.wr_cause) begin
                cause_q[23]  <= wr.wr_data[23]; // IV
                cause_q[9:8] <= wr.wr_data[9:8];
            end
            if (wr.wr_ebase) begin
                ebase_q[29:12] <= wr.wr_data[29:12];
            end
            if (wr.exp_take) begin
                status_q[1]  <= 1'b1;
                cause_q[31]  <= wr.exp_bd;
                cause_q[6:2] <= wr.exp_code;
            end
            // EXL return wins over a same-cycle entry
            if (wr.exl_clear) begin
                status_q[1] <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr.wr_epc) begin
            epc_q <= wr.wr_data;
        end
        if (wr.exp_take) begin
            epc_q <= wr.exp_epc;
            if (wr.exp_badv_we) begin
                badvaddr_q <= wr.exp_bad_vaddr;
            end
        end
    end

    assign status_o   = status_q;
    assign cause_o    = cause_q;
    assign epc_o      = epc_q;
    assign ebase_o    = ebase_q;
    assign badvaddr_o = badvaddr_q;

    assign user_mode_o       = status_q[4:1] == 4'b1000; // UM with ERL, EXL clear
    assign allow_int_o       = status_q[2:0] == 3'b001;
    assign in_exl_o          = status_q[1];
    assign boot_exp_vec_o    = status_q[22];
    assign interrupt_mask_o  = status_q[15:8];
    assign special_int_vec_o = cause_q[23];
    assign software_int_o    = cause_q[9:8];

endmodule

// File: hdl/cp0_mmu_regs.sv
`include "cp0_cfg.svh"

module cp0_mmu_regs (
    input  logic                 clk,
    input  logic                 rst_n,
    cp0_wr_if.regs               wr,
    output cp0_pkg::cp0_word_t   index_o,
    output cp0_pkg::cp0_word_t   entrylo0_o,
    output cp0_pkg::cp0_word_t   entrylo1_o,
    output cp0_pkg::cp0_word_t   entryhi_o,
    output cp0_pkg::cp0_word_t   context_o,
    output cp0_pkg::cp0_word_t   config_o,
    output cp0_pkg::cp0_asid_t   asid_o,
    output cp0_pkg::cp0_tlbcfg_t tlb_config_o,
    output logic                 kseg0_uncached_o
);

    cp0_pkg::cp0_word_t index_q;
    logic [29:0]        lo0_q;
    logic [29:0]        lo1_q;
    cp0_pkg::cp0_vpn2_t hi_vpn2_q;
    cp0_pkg::cp0_asid_t hi_asid_q;
    logic [8:0]         ctx_ptebase_q;
    cp0_pkg::cp0_vpn2_t ctx_badvpn2_q;
    logic [2:0]         k0_q;
    cp0_pkg::cp0_vpn2_t exp_vpn2;

    assign exp_vpn2 = wr.exp_bad_vaddr[31:13];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            index_q          <= '0;
            lo0_q            <= '0;
            lo1_q            <= '0;
            hi_vpn2_q        <= '0;
            hi_asid_q        <= '0;
            ctx_ptebase_q    <= '0;
            ctx_badvpn2_q    <= '0;
            k0_q             <= '0;
            kseg0_uncached_o <= 1'b0;
        end else begin
            if (wr.wr_index)    index_q[3:0] <= wr.wr_data[3:0];
            if (wr.probe_load)  index_q <= wr.probe_result; // P bit included
            if (wr.wr_entrylo0) lo0_q <= wr.wr_data[29:0];
            if (wr.wr_entrylo1) lo1_q <= wr.wr_data[29:0];
            if (wr.wr_context)  ctx_ptebase_q <= wr.wr_data[31:23];
            if (wr.wr_entryhi) begin
                hi_vpn2_q <= wr.wr_data[31:13];
                hi_asid_q <= wr.wr_data[7:0];
            end
            if (wr.wr_config) begin
                k0_q             <= wr.wr_data[2:0];
                kseg0_uncached_o <= wr.wr_data[2:0] == `CP0_KSEG0_UNCACHED_K0;
            end
            if (wr.exp_take) begin
                hi_vpn2_q     <= exp_vpn2;
                ctx_badvpn2_q <= exp_vpn2;
                if (wr.exp_asid_we) hi_asid_q <= wr.exp_asid;
            end
        end
    end

    assign index_o    = index_q;
    assign entrylo0_o = {2'b00, lo0_q};
    assign entrylo1_o = {2'b00, lo1_q};
    assign entryhi_o  = {hi_vpn2_q, 5'd0, hi_asid_q};
    assign context_o  = {ctx_ptebase_q, ctx_badvpn2_q, 4'd0};
    assign config_o   = {29'd0, k0_q};
    assign asid_o     = hi_asid_q;

    // C fields, ASID, G, VPN2, then PFN/D/V per page and the index
    assign tlb_config_o = {lo0_q[5:3], lo1_q[5:3], hi_asid_q, lo1_q[0] & lo0_q[0], hi_vpn2_q,
                           lo1_q[29:6], lo1_q[2:1], lo0_q[29:6], lo0_q[2:1], index_q[3:0]};

endmodule

// File: hdl/cp0_read_mux.sv
`include "cp0_cfg.svh"

module cp0_read_mux (
    input  cp0_pkg::cp0_regsel_t rd_addr_i,
    input  cp0_pkg::cp0_regsel_t dbg_rd_addr_i,
    input  logic [5:0]           hardware_int_i,
    input  cp0_pkg::cp0_word_t   index_i,
    input  cp0_pkg::cp0_word_t   entrylo0_i,
    input  cp0_pkg::cp0_word_t   entrylo1_i,
    input  cp0_pkg::cp0_word_t   context_i,
    input  cp0_pkg::cp0_word_t   badvaddr_i,
    input  cp0_pkg::cp0_word_t   count_i,
    input  cp0_pkg::cp0_word_t   entryhi_i,
    input  cp0_pkg::cp0_word_t   compare_i,
    input  cp0_pkg::cp0_word_t   status_i,
    input  cp0_pkg::cp0_word_t   cause_i,
    input  cp0_pkg::cp0_word_t   epc_i,
    input  cp0_pkg::cp0_word_t   ebase_i,
    input  cp0_pkg::cp0_word_t   config_i,
    output cp0_pkg::cp0_word_t   data_o,
    output cp0_pkg::cp0_word_t   dbg_data_o
);

    cp0_pkg::cp0_regsel_t port_addr [2];
    cp0_pkg::cp0_word_t   port_data [2];

    assign port_addr[0] = rd_addr_i;
    assign port_addr[1] = dbg_rd_addr_i; // Debugger
    assign data_o       = port_data[0];
    assign dbg_data_o   = port_data[1];

    for (genvar p = 0; p < 2; p++) begin : g_port
        cp0_pkg::cp0_word_t rd_word;

        always_comb begin
            case (port_addr[p])
                `CP0_INDEX:    rd_word = {index_i[31], 27'd0, index_i[3:0]};
                `CP0_ENTRYLO0: rd_word = {2'b00, entrylo0_i[29:0]};
                `CP0_ENTRYLO1: rd_word = {2'b00, entrylo1_i[29:0]};
                `CP0_CONTEXT:  rd_word = {context_i[31:4], 4'd0};
                `CP0_BADVADDR: rd_word = badvaddr_i;
                `CP0_COUNT:    rd_word = count_i;
                `CP0_ENTRYHI:  rd_word = {entryhi_i[31:13], 5'd0, entryhi_i[7:0]};
                `CP0_COMPARE:  rd_word = compare_i;
                `CP0_STATUS:   rd_word = status_i;
                `CP0_CAUSE:    rd_word = {cause_i[31], 7'd0, cause_i[23], 7'd0, hardware_int_i,
                                          cause_i[9:8], 1'b0, cause_i[6:2], 2'b00};
                `CP0_EPC:      rd_word = epc_i;
                `CP0_PRID:     rd_word = `CP0_PRID_VAL;
                `CP0_EBASE:    rd_word = {2'b10, ebase_i[29:12], 12'd0};
                `CP0_CONFIG:   rd_word = {1'b1, 21'd0, 3'd1, 4'd0, config_i[2:0]}; // Release 1
                `CP0_CONFIG1:  rd_word = `CP0_CONFIG1_VAL;
                default:       rd_word = '0;
            endcase
        end

        assign port_data[p] = rd_word;
    end

endmodule

// File: hdl/cp0_top.sv
module cp0_top (
    input  logic                 clk,
    input  logic                 rst_n,
    input  cp0_pkg::cp0_regsel_t rd_addr_i,
    output cp0_pkg::cp0_word_t   data_o,
    input  logic                 we_i,
    input  cp0_pkg::cp0_regsel_t wr_addr_i,
    input  cp0_pkg::cp0_word_t   data_i,
    input  logic [5:0]           hardware_int_i,
    output logic                 timer_int_o,
    output logic                 user_mode_o,
    output cp0_pkg::cp0_word_t   ebase_o,
    output cp0_pkg::cp0_word_t   epc_o,
    output cp0_pkg::cp0_tlbcfg_t tlb_config_o,
    output logic                 allow_int_o,
    output logic [1:0]           software_int_o,
    output logic [7:0]           interrupt_mask_o,
    output logic                 special_int_vec_o,
    output logic                 boot_exp_vec_o,
    output cp0_pkg::cp0_asid_t   asid_o,
    output logic                 in_exl_o,
    output logic                 kseg0_uncached_o,
    input  logic                 clean_exl_i,
    input  logic                 en_exp_i,
    input  cp0_pkg::cp0_word_t   exp_epc_i,
    input  logic                 exp_bd_i,
    input  cp0_pkg::cp0_excode_t exp_code_i,
    input  cp0_pkg::cp0_word_t   exp_bad_vaddr_i,
    input  logic                 exp_badv_we_i,
    input  cp0_pkg::cp0_asid_t   exp_asid_i,
    input  logic                 exp_asid_we_i,
    input  logic                 we_probe_i,
    input  cp0_pkg::cp0_word_t   probe_result_i,
    input  cp0_pkg::cp0_regsel_t dbg_rd_addr_i,
    output cp0_pkg::cp0_word_t   dbg_data_o
);

    cp0_pkg::cp0_word_t count, compare, status, cause, badvaddr;
    cp0_pkg::cp0_word_t index, entrylo0, entrylo1, entryhi, context_w, config_w;

    cp0_wr_if wr_bus ();

    cp0_ctrl u_ctrl (
        .we_i, .wr_addr_i, .data_i, .en_exp_i, .exp_epc_i, .exp_bd_i, .exp_code_i,
        .exp_bad_vaddr_i, .exp_badv_we_i, .exp_asid_i, .exp_asid_we_i, .clean_exl_i,
        .we_probe_i, .probe_result_i, .wr(wr_bus.ctrl)
    );

    cp0_timer u_timer (
        .clk, .rst_n, .wr(wr_bus.regs), .count_o(count), .compare_o(compare), .timer_int_o
    );

    cp0_except_regs u_except_regs (
        .clk, .rst_n, .wr(wr_bus.regs), .status_o(status), .cause_o(cause), .epc_o,
        .ebase_o, .badvaddr_o(badvaddr), .user_mode_o, .allow_int_o, .in_exl_o,
        .boot_exp_vec_o, .special_int_vec_o, .interrupt_mask_o, .software_int_o
    );

    cp0_mmu_regs u_mmu_regs (
        .clk, .rst_n, .wr(wr_bus.regs), .index_o(index), .entrylo0_o(entrylo0),
        .entrylo1_o(entrylo1), .entryhi_o(entryhi), .context_o(context_w),
        .config_o(config_w), .asid_o, .tlb_config_o, .kseg0_uncached_o
    );

    cp0_read_mux u_read_mux (
        .rd_addr_i, .dbg_rd_addr_i, .hardware_int_i, .index_i(index),
        .entrylo0_i(entrylo0), .entrylo1_i(entrylo1), .context_i(context_w),
        .badvaddr_i(badvaddr), .count_i(count), .entryhi_i(entryhi), .compare_i(compare),
        .status_i(status), .cause_i(cause), .epc_i(epc_o), .ebase_i(ebase_o),
        .config_i(config_w), .data_o, .dbg_data_o
    );

endmodule

// File: sim/tb_clk_gen.sv
module tb_clk_gen (
    output logic clk_o
);

    initial clk_o = 1'b0;

    always #50 clk_o = ~clk_o; // Period 100

endmodule

// File: sim/cp0_tb.sv
`include "cp0_cfg.svh"

module cp0_tb;

    logic                 clk, rst_n;
    logic                 we_i, en_exp_i, exp_bd_i, exp_badv_we_i, exp_asid_we_i;
    logic                 clean_exl_i, we_probe_i, timer_int_o, user_mode_o, allow_int_o;
    logic                 special_int_vec_o, boot_exp_vec_o, in_exl_o, kseg0_uncached_o;
    logic [1:0]           software_int_o;
    logic [5:0]           hardware_int_i;
    logic [7:0]           interrupt_mask_o;
    cp0_pkg::cp0_regsel_t rd_addr_i, dbg_rd_addr_i, wr_addr_i;
    cp0_pkg::cp0_word_t   data_i, exp_epc_i, exp_bad_vaddr_i, probe_result_i;
    cp0_pkg::cp0_word_t   data_o, dbg_data_o, ebase_o, epc_o;
    cp0_pkg::cp0_excode_t exp_code_i;
    cp0_pkg::cp0_asid_t   exp_asid_i, asid_o;
    cp0_pkg::cp0_tlbcfg_t tlb_config_o;

    integer               seed = 32'hb80a;
    int                   errors = 0;
    int                   checks = 0;
    int                   cycles = 0;
    cp0_pkg::cp0_word_t   last_wr;
    cp0_pkg::cp0_word_t   cause_sw; // Cause bits set by software
    cp0_pkg::cp0_word_t   ctx_sw;   // Context PTEBase as written

    tb_clk_gen u_clk_gen (.clk_o(clk));

    cp0_top dut (.*);

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= 2000) begin
            $display("Timeout: no result after %0d cycles", cycles);
            $display("tests failed");
            $finish;
        end
    end

    task automatic check_word(input string what, input cp0_pkg::cp0_word_t got,
                              input cp0_pkg::cp0_word_t want);
        checks++;
        assert (got === want) else begin
            errors++;
            $display("** Error at %0t: %s is %h, expected %h", $time, what, got, want);
        end
    endtask

    task automatic check_bit(input string what, input logic got, input logic want);
        check_word(what, {31'd0, got}, {31'd0, want});
    endtask

    task automatic write_reg(input cp0_pkg::cp0_regsel_t addr, input cp0_pkg::cp0_word_t value);
        @(posedge clk);
        we_i      <= 1'b1;
        wr_addr_i <= addr;
        data_i    <= value;
        @(posedge clk);
        we_i <= 1'b0;
    endtask

    // CPU and debugger ports read the same register
    task automatic read_check(input string what, input cp0_pkg::cp0_regsel_t addr,
                              input cp0_pkg::cp0_word_t want);
        @(posedge clk);
        rd_addr_i     <= addr;
        dbg_rd_addr_i <= addr;
        @(negedge clk);
        check_word({what, " (cpu port)"}, data_o, want);
        check_word({what, " (debug port)"}, dbg_data_o, want);
    endtask

    task automatic rw_check(input string what, input cp0_pkg::cp0_regsel_t addr,
                            input cp0_pkg::cp0_word_t mask, input cp0_pkg::cp0_word_t fixed);
        last_wr = $random(seed);
        write_reg(addr, last_wr);
        read_check(what, addr, (last_wr & mask) | fixed);
    endtask

    // misc holds code in 4:0, BD in 5 and ASID in 15:8
    task automatic raise_exception(input cp0_pkg::cp0_word_t epc, input cp0_pkg::cp0_word_t bad,
                                   input cp0_pkg::cp0_word_t misc, input logic badv_we,
                                   input logic clean);
        @(posedge clk);
        en_exp_i        <= 1'b1;
        exp_epc_i       <= epc;
        exp_code_i      <= misc[4:0];
        exp_bd_i        <= misc[5];
        exp_bad_vaddr_i <= bad;
        exp_badv_we_i   <= badv_we;
        exp_asid_i      <= misc[15:8];
        exp_asid_we_i   <= 1'b1;
        clean_exl_i     <= clean;
        @(posedge clk);
        en_exp_i    <= 1'b0;
        clean_exl_i <= 1'b0;
    endtask

    // C of both pages, ASID, G, VPN2, PFN/D/V of page 1 then page 0, index
    function automatic cp0_pkg::cp0_tlbcfg_t pack_tlb_entry(input cp0_pkg::cp0_word_t lo0,
            input cp0_pkg::cp0_word_t lo1, input cp0_pkg::cp0_word_t hi,
            input cp0_pkg::cp0_word_t idx);
        return {lo0[5:3], lo1[5:3], hi[7:0], lo0[0] & lo1[0], hi[31:13],
                lo1[29:6], lo1[2:1], lo0[29:6], lo0[2:1], idx[3:0]};
    endfunction

    task automatic test_reset();
        read_check("Status", `CP0_STATUS, 32'h10400004);
        read_check("EBase", `CP0_EBASE, 32'h80000000);
        read_check("PRId", `CP0_PRID, `CP0_PRID_VAL);
        read_check("Config1", `CP0_CONFIG1, `CP0_CONFIG1_VAL);
        check_bit("timer_int_o", timer_int_o, 1'b0);
        check_bit("kseg0_uncached_o", kseg0_uncached_o, 1'b0);
        check_bit("boot_exp_vec_o", boot_exp_vec_o, 1'b1);
        check_bit("in_exl_o", in_exl_o, 1'b0);
        check_bit("user_mode_o", user_mode_o, 1'b0);
        check_bit("allow_int_o", allow_int_o, 1'b0);
    endtask

    task automatic test_rw_masks();
        cp0_pkg::cp0_word_t r;
        r = $random(seed);
        @(posedge clk);
        hardware_int_i <= r[5:0];
        rw_check("Index", `CP0_INDEX, 32'h0000000f, 32'h0);
        rw_check("EntryLo0", `CP0_ENTRYLO0, 32'h3fffffff, 32'h0);
        rw_check("EntryLo1", `CP0_ENTRYLO1, 32'h3fffffff, 32'h0);
        rw_check("Context", `CP0_CONTEXT, 32'hff800000, 32'h0);
        ctx_sw = last_wr & 32'hff800000;
        rw_check("EntryHi", `CP0_ENTRYHI, 32'hffffe0ff, 32'h0);
        check_word("asid_o", asid_o, last_wr[7:0]);
        rw_check("Compare", `CP0_COMPARE, 32'hffffffff, 32'h0);
        rw_check("Status", `CP0_STATUS, 32'h1040ff17, 32'h0); // Reset bits lie inside the mask
        // User mode and interrupts need both EXL and ERL clear
        check_bit("user_mode_o", user_mode_o, last_wr[4] & ~last_wr[2] & ~last_wr[1]);
        check_bit("allow_int_o", allow_int_o, last_wr[0] & ~last_wr[2] & ~last_wr[1]);
        check_word("interrupt_mask_o", interrupt_mask_o, last_wr[15:8]);
        check_bit("boot_exp_vec_o", boot_exp_vec_o, last_wr[22]);
        rw_check("Cause", `CP0_CAUSE, 32'h00800300, {16'd0, r[5:0], 10'd0});
        cause_sw = last_wr & 32'h00800300;
        check_word("software_int_o", software_int_o, last_wr[9:8]);
        check_bit("special_int_vec_o", special_int_vec_o, last_wr[23]);
        rw_check("EPC", `CP0_EPC, 32'hffffffff, 32'h0);
        check_word("epc_o", epc_o, last_wr);
        rw_check("EBase", `CP0_EBASE, 32'h3ffff000, 32'h80000000);
        check_word("ebase_o", ebase_o, (last_wr & 32'h3ffff000) | 32'h80000000);
        rw_check("Config", `CP0_CONFIG, 32'h00000007, 32'h80000080); // M set, MT standard TLB
        rw_check("PRId", `CP0_PRID, 32'h0, `CP0_PRID_VAL);
        last_wr = $random(seed);
        write_reg(`CP0_COUNT, last_wr);
        read_check("Count", `CP0_COUNT, last_wr + 32'd1); // One tick since the write
    endtask

    task automatic test_timer();
        int waited;
        write_reg(`CP0_COUNT, 32'd10);
        write_reg(`CP0_COMPARE, 32'd20);
        waited = 0;
        do begin
            @(negedge clk);
            waited++;
        end while (!timer_int_o && waited < 12);
        check_bit("timer_int_o on Count match", timer_int_o, 1'b1);
        repeat (5) begin
            @(negedge clk);
            check_bit("timer_int_o held", timer_int_o, 1'b1);
        end
        write_reg(`CP0_COMPARE, 32'd0);
        @(negedge clk);
        check_bit("timer_int_o after Compare write", timer_int_o, 1'b0);
        write_reg(`CP0_COUNT, 32'hfffffff0); // Count wraps through 0
        repeat (40) begin
            @(negedge clk);
            check_bit("timer_int_o with Compare 0", timer_int_o, 1'b0);
        end
    endtask

    task automatic test_exception();
        cp0_pkg::cp0_word_t epc, bad, misc;
        epc  = $random(seed);
        bad  = $random(seed);
        misc = $random(seed);
        raise_exception(epc, bad, misc, 1'b1, 1'b0);
        read_check("EPC", `CP0_EPC, epc);
        check_bit("in_exl_o after entry", in_exl_o, 1'b1);
        check_word("asid_o after entry", asid_o, misc[15:8]);
        read_check("Cause", `CP0_CAUSE,
                   cause_sw | {misc[5], 15'd0, hardware_int_i, 3'd0, misc[4:0], 2'd0});
        read_check("BadVAddr", `CP0_BADVADDR, bad);
        read_check("EntryHi", `CP0_ENTRYHI, {bad[31:13], 5'd0, misc[15:8]});
        read_check("Context", `CP0_CONTEXT, ctx_sw | {9'd0, bad[31:13], 4'd0});
        @(posedge clk);
        clean_exl_i <= 1'b1;
        @(posedge clk);
        clean_exl_i <= 1'b0;
        @(negedge clk);
        check_bit("in_exl_o after EXL clear", in_exl_o, 1'b0);
        // Entry and return in the same cycle with BadVAddr left alone
        raise_exception(~epc, ~bad, misc, 1'b0, 1'b1);
        @(negedge clk);
        check_bit("in_exl_o after entry with clear", in_exl_o, 1'b0);
        read_check("BadVAddr kept", `CP0_BADVADDR, bad);
    endtask

    task automatic test_probe_tlb();
        cp0_pkg::cp0_word_t   probe, lo0, lo1, hi;
        cp0_pkg::cp0_tlbcfg_t want;
        probe = $random(seed);
        lo0   = $random(seed);
        lo1   = $random(seed);
        hi    = $random(seed);
        @(posedge clk);
        we_i           <= 1'b1;
        wr_addr_i      <= `CP0_INDEX;
        data_i         <= ~probe;
        we_probe_i     <= 1'b1;
        probe_result_i <= probe;
        @(posedge clk);
        we_i       <= 1'b0;
        we_probe_i <= 1'b0;
        read_check("Index after probe", `CP0_INDEX, probe & 32'h8000000f);
        write_reg(`CP0_ENTRYLO0, lo0);
        write_reg(`CP0_ENTRYLO1, lo1);
        write_reg(`CP0_ENTRYHI, hi);
        want = pack_tlb_entry(lo0, lo1, hi, probe);
        @(negedge clk);
        checks++;
        assert (tlb_config_o === want) else begin
            errors++;
            $display("** Error at %0t: tlb_config_o is %h, expected %h", $time,
                     tlb_config_o, want);
        end
        write_reg(`CP0_CONFIG, 32'd2);
        @(negedge clk);
        check_bit("kseg0_uncached_o with K0 = 2", kseg0_uncached_o, 1'b1);
        write_reg(`CP0_CONFIG, 32'd3);
        @(negedge clk);
        check_bit("kseg0_uncached_o with K0 = 3", kseg0_uncached_o, 1'b0);
    endtask

    initial begin
        rst_n <= 1'b0;
        {we_i, en_exp_i, exp_bd_i, exp_badv_we_i, exp_asid_we_i, clean_exl_i, we_probe_i} <= '0;
        {wr_addr_i, rd_addr_i, dbg_rd_addr_i, hardware_int_i} <= '0;
        {data_i, exp_epc_i, exp_bad_vaddr_i, probe_result_i, exp_code_i, exp_asid_i} <= '0;
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        test_reset();
        test_rw_masks();
        test_timer();
        test_exception();
        test_probe_tlb();
        $display("Summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

// File: flist.f
+incdir+hdl
hdl/cp0_pkg.sv
hdl/cp0_wr_if.sv
hdl/cp0_ctrl.sv
hdl/cp0_timer.sv
hdl/cp0_except_regs.sv
hdl/cp0_mmu_regs.sv
hdl/cp0_read_mux.sv
hdl/cp0_top.sv
sim/tb_clk_gen.sv
sim/cp0_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       := cp0_tb
FLIST     := flist.f
PASS_MSG  := all tests passed

SRCS := $(filter-out +incdir+%,$(shell cat $(FLIST))) $(wildcard hdl/*.svh)
BIN  := obj_dir/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf obj_dir
